// ==== hdl/rdsplit_pkg.sv ====
package rdsplit_pkg;

    // bus widths
    localparam int addr_w    = 32;
    localparam int meta_w    = 4;
    localparam int num_tags  = 8;
    localparam int tag_w     = 3;
    localparam int tag_cnt_w = 4;

    // command queue geometry
    localparam int q_depth = 4;
    localparam int q_ptr_w = 2;

    // max read request size codes
    localparam logic [2:0] ms_128  = 3'd0;
    localparam logic [2:0] ms_256  = 3'd1;
    localparam logic [2:0] ms_512  = 3'd2;
    localparam logic [2:0] ms_1024 = 3'd3;
    localparam logic [2:0] ms_2048 = 3'd4;
    localparam logic [2:0] ms_4096 = 3'd5;

    // len of 0 means 1024 dwords
    typedef struct packed {
        logic [addr_w-1:2] addr;
        logic [9:0]        len;
        logic [meta_w-1:0] meta;
    } rd_cmd_t;

    typedef struct packed {
        logic [addr_w-1:2] addr;
        logic [9:0]        len;
        logic [meta_w-1:0] meta;
        logic              last;
    } rd_piece_t;

    typedef struct packed {
        rd_piece_t         piece;
        logic [tag_w-1:0]  tag;
    } rd_req_t;

    // request size in dwords; unknown codes saturate at 4 KB
    function automatic logic [10:0] max_len_dw(input logic [2:0] code);
        case (code)
            ms_128:  return 11'd32;
            ms_256:  return 11'd64;
            ms_512:  return 11'd128;
            ms_1024: return 11'd256;
            ms_2048: return 11'd512;
            ms_4096: return 11'd1024;
            default: return 11'd1024;
        endcase
    endfunction

endpackage

// ==== hdl/cmd_queue.sv ====
`timescale 1ns/10ps

module cmd_queue (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  rdsplit_pkg::rd_cmd_t cmd,

    output logic                 q_valid,
    input  logic                 q_ready,
    output rdsplit_pkg::rd_cmd_t q_cmd
);

    rdsplit_pkg::rd_cmd_t mem [rdsplit_pkg::q_depth];

    logic [rdsplit_pkg::q_ptr_w-1:0] wr_ptr;
    logic [rdsplit_pkg::q_ptr_w-1:0] rd_ptr;
    logic [rdsplit_pkg::q_ptr_w:0]   count;

    logic push;
    logic pop;

    assign cmd_ready = (count != rdsplit_pkg::q_depth);
    assign q_valid   = (count != '0);
    assign q_cmd     = mem[rd_ptr];

    assign push = cmd_valid && cmd_ready;
    assign pop  = q_valid && q_ready;

    // storage, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd;
        end
    end

    // pointers wrap naturally at four entries
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hdl/cmd_split.sv ====
`timescale 1ns/10ps

module cmd_split (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [2:0]             max_size,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  rdsplit_pkg::rd_cmd_t   in_cmd,

    output logic                   out_valid,
    input  logic                   out_ready,
    output rdsplit_pkg::rd_piece_t out_piece
);

    // decoded request size
    logic [10:0] size_dw;
    logic [10:0] max_len;
    logic [9:0]  max_mask;

    // split state
    logic                              split_valid;
    logic                              split_ready;
    logic                              split_last;
    logic [rdsplit_pkg::addr_w-1:2]    split_addr;
    logic [10:0]                       split_len;
    logic [10:0]                       split_inc;
    logic [rdsplit_pkg::meta_w-1:0]    split_meta;

    logic [10:0] first_inc;
    logic [10:0] in_len_full;
    logic [9:0]  next_out_len;

    assign size_dw = rdsplit_pkg::max_len_dw(max_size);

    // max_size is static while idle, so one cycle of delay is harmless
    always_ff @(posedge clk) begin
        max_len  <= size_dw;
        max_mask <= size_dw[9:0] - 10'd1;
    end

    assign in_ready    = !split_valid;
    assign split_ready = !out_valid || out_ready;

    // len 0 stands for a full 1024 dwords
    assign in_len_full = (in_cmd.len == 10'd0) ? 11'd1024 : {1'b0, in_cmd.len};

    // distance from the start address to the next boundary
    assign first_inc = max_len - {1'b0, in_cmd.addr[11:2] & max_mask};

    // remainder fits in this step, including 1024 at 4 KB aligned
    assign split_last = (split_len <= split_inc);

    // 1024 encodes back to zero through truncation
    assign next_out_len = split_last ? split_len[9:0] : split_inc[9:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            split_valid <= 1'b0;
        end else begin
            if (split_valid && split_ready && split_last) begin
                split_valid <= 1'b0;
            end
            if (in_valid && in_ready) begin
                split_valid <= 1'b1;
            end
        end
    end

    // load from the input while idle, step after each issued piece
    always_ff @(posedge clk) begin
        if (!split_valid) begin
            split_addr <= in_cmd.addr;
            split_len  <= in_len_full;
            split_inc  <= first_inc;
            split_meta <= in_cmd.meta;
        end else if (split_ready) begin
            // full-width add so pieces may carry across a 4 KB page
            split_addr <= split_addr + {{(rdsplit_pkg::addr_w-13){1'b0}}, split_inc};
            split_len  <= split_len - split_inc;
            split_inc  <= max_len;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (split_valid && split_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (split_valid && split_ready) begin
            out_piece.addr <= split_addr;
            out_piece.len  <= next_out_len;
            out_piece.meta <= split_meta;
            out_piece.last <= split_last;
        end
    end

endmodule

// ==== hdl/tag_pool.sv ====
`timescale 1ns/10ps

module tag_pool (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              piece_valid,
    output logic                              piece_ready,
    input  rdsplit_pkg::rd_piece_t            piece,

    output logic                              req_valid,
    input  logic                              req_ready,
    output rdsplit_pkg::rd_req_t              req,

    input  logic                              tag_release_valid,
    input  logic [rdsplit_pkg::tag_w-1:0]     tag_release,

    output logic [rdsplit_pkg::tag_cnt_w-1:0] tags_free
);

    // one bit per tag, set means free
    logic [rdsplit_pkg::num_tags-1:0] free_map;
    logic [rdsplit_pkg::tag_w-1:0]    free_tag;
    logic                             any_free;
    logic                             issue;

    assign any_free = |free_map;

    // lowest free tag wins
    always_comb begin
        free_tag = '0;
        for (int i = rdsplit_pkg::num_tags - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                free_tag = i[rdsplit_pkg::tag_w-1:0];
            end
        end
    end

    // count of free tags for the client
    always_comb begin
        tags_free = '0;
        for (int i = 0; i < rdsplit_pkg::num_tags; i++) begin
            tags_free += free_map[i];
        end
    end

    // pass-through data path, stalled while the pool is empty
    assign req_valid   = piece_valid && any_free;
    assign piece_ready = req_ready && any_free;
    assign req.piece   = piece;
    assign req.tag     = free_tag;

    assign issue = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            free_map <= '1;
        end else begin
            // issue and release in the same cycle both apply
            if (issue) begin
                free_map[free_tag] <= 1'b0;
            end
            if (tag_release_valid) begin
                free_map[tag_release] <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/rdsplit_top.sv ====
`timescale 1ns/10ps

module rdsplit_top (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [2:0]                        max_size,

    input  logic                              cmd_valid,
    output logic                              cmd_ready,
    input  rdsplit_pkg::rd_cmd_t              cmd,

    output logic                              req_valid,
    input  logic                              req_ready,
    output rdsplit_pkg::rd_req_t              req,

    input  logic                              tag_release_valid,
    input  logic [rdsplit_pkg::tag_w-1:0]     tag_release,
    output logic [rdsplit_pkg::tag_cnt_w-1:0] tags_free
);

    // queue to splitter
    logic                   q_valid;
    logic                   q_ready;
    rdsplit_pkg::rd_cmd_t   q_cmd;

    // splitter to tag pool
    logic                   piece_valid;
    logic                   piece_ready;
    rdsplit_pkg::rd_piece_t piece;

    cmd_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_cmd     (q_cmd)
    );

    cmd_split u_split (
        .clk       (clk),
        .rst       (rst),
        .max_size  (max_size),
        .in_valid  (q_valid),
        .in_ready  (q_ready),
        .in_cmd    (q_cmd),
        .out_valid (piece_valid),
        .out_ready (piece_ready),
        .out_piece (piece)
    );

    tag_pool u_tags (
        .clk               (clk),
        .rst               (rst),
        .piece_valid       (piece_valid),
        .piece_ready       (piece_ready),
        .piece             (piece),
        .req_valid         (req_valid),
        .req_ready         (req_ready),
        .req               (req),
        .tag_release_valid (tag_release_valid),
        .tag_release       (tag_release),
        .tags_free         (tags_free)
    );

endmodule

// ==== testbench/rdsplit_checker.sv ====
`timescale 1ns/10ps

module rdsplit_checker (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [2:0]                        max_size,
    input  logic                              cmd_valid,
    input  logic                              cmd_ready,
    input  rdsplit_pkg::rd_cmd_t              cmd,
    input  logic                              req_valid,
    input  logic                              req_ready,
    input  rdsplit_pkg::rd_req_t              req,
    input  logic                              tag_release_valid,
    input  logic [rdsplit_pkg::tag_w-1:0]     tag_release,
    input  logic [rdsplit_pkg::tag_cnt_w-1:0] tags_free,
    output int                                err_count,
    output int                                req_count,
    output int                                pending
);

    rdsplit_pkg::rd_piece_t           expected [$];
    rdsplit_pkg::rd_piece_t           want;
    logic [rdsplit_pkg::num_tags-1:0] outstanding;
    int                               low;
    int                               open_cmds;
    int                               errors;
    int                               reqs;

    task automatic flag_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // walk the command from boundary to boundary of the request size
    function automatic void build_expected(input rdsplit_pkg::rd_cmd_t c, input logic [2:0] code);
        int          size;
        int          left;
        int          room;
        int          n;
        logic [29:0] a;
        size = (code > 3'd5) ? 1024 : (32 << code);
        left = (c.len == 10'd0) ? 1024 : int'(c.len);
        a = c.addr;
        while (left > 0) begin
            room = size - int'(a % size);
            n = (left < room) ? left : room;
            expected.push_back('{addr: a, len: 10'(n), meta: c.meta, last: (n == left)});
            a += 30'(n);
            left -= n;
        end
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            expected.delete();
            outstanding = '0;
            open_cmds = 0;
            errors = 0;
            reqs = 0;
        end else begin
            if (tags_free != rdsplit_pkg::num_tags - $countones(outstanding)) begin
                flag_error($sformatf("tags_free %0d with %0d tags outstanding",
                                     tags_free, $countones(outstanding)));
            end
            if (req_valid && outstanding == '1) begin
                flag_error("req_valid high while every tag is outstanding");
            end
            // the queue can only be full with four unfinished commands
            if (!cmd_ready && open_cmds < rdsplit_pkg::q_depth) begin
                flag_error($sformatf("cmd_ready low with %0d commands unfinished",
                                     open_cmds));
            end
            if (cmd_valid && cmd_ready) begin
                build_expected(cmd, max_size);
                open_cmds++;
            end
            if (req_valid && req_ready) begin
                // the pool hands out its lowest free tag
                low = 0;
                while (low < rdsplit_pkg::num_tags - 1 && outstanding[low]) low++;
                if (expected.size() == 0) begin
                    flag_error("request with no piece pending");
                end else begin
                    want = expected.pop_front();
                    if (want.last) begin
                        open_cmds--;
                    end
                    if (req.piece !== want) begin
                        flag_error($sformatf("piece %h len %0d meta %h last %b, want %h %0d %h %b",
                                             req.piece.addr, req.piece.len, req.piece.meta,
                                             req.piece.last, want.addr, want.len, want.meta,
                                             want.last));
                    end
                end
                if (outstanding[req.tag] || req.tag != low) begin
                    flag_error($sformatf("tag %0d issued, lowest free is %0d", req.tag, low));
                end
                outstanding[req.tag] = 1'b1;
                reqs++;
            end
            if (tag_release_valid) begin
                outstanding[tag_release] = 1'b0;
            end
        end
        // counters for the stimulus process
        err_count <= errors;
        req_count <= reqs;
        pending   <= expected.size();
    end

endmodule

// ==== testbench/tb_rdsplit.sv ====
`timescale 1ns/10ps

module tb_rdsplit;

    // commands over all five tests
    localparam int total_cmds = 245;

    logic                              clk;
    logic                              rst;
    logic [2:0]                        max_size;
    logic                              cmd_valid;
    logic                              cmd_ready;
    rdsplit_pkg::rd_cmd_t              cmd;
    logic                              req_valid;
    logic                              req_ready = 1'b0;
    rdsplit_pkg::rd_req_t              req;
    logic                              tag_release_valid = 1'b0;
    logic [rdsplit_pkg::tag_w-1:0]     tag_release = '0;
    logic [rdsplit_pkg::tag_cnt_w-1:0] tags_free;
    int                                err_count;
    int                                req_count;
    int                                pending;

    logic [31:0]                   lcg = 32'h432b_be1a;
    // the sink draws from its own stream
    logic [31:0]                   sink_lcg = ~32'h432b_be1a;
    logic                          release_en = 1'b1;
    logic                          release_one = 1'b0;
    logic                          ready_random = 1'b0;
    int                            cycle = 0;
    int                            test_num = 0;
    int                            test_fails = 0;
    int                            err_base = 0;
    string                         test_name = "reset";
    logic [rdsplit_pkg::tag_w-1:0] rel_tag [$];
    int                            rel_due [$];

    rdsplit_top dut (.*);
    rdsplit_checker u_check (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (200 * total_cmds + 1000) @(posedge clk);
        $display("timeout in test %0d (%s), requests stopped coming", test_num, test_name);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state ^ (state >> 16);
    endfunction

    // request sink with random back-pressure and delayed tag return
    always @(posedge clk) begin
        cycle <= cycle + 1;
        req_ready <= ready_random ? (next_rand(sink_lcg) % 4 != 0) : 1'b1;
        tag_release_valid <= 1'b0;
        if (req_valid && req_ready) begin
            rel_tag.push_back(req.tag);
            rel_due.push_back(cycle + 1 + int'(next_rand(sink_lcg) % 16));
        end
        if (rel_tag.size() != 0 && (release_one || (release_en && rel_due[0] <= cycle))) begin
            tag_release_valid <= 1'b1;
            tag_release <= rel_tag.pop_front();
            rel_due.delete(0);
        end
    end

    task automatic send_cmd(input logic [29:0] addr, input logic [9:0] len);
        cmd_valid <= 1'b1;
        cmd <= '{addr: addr, len: len, meta: 4'(next_rand(lcg))};
        @(posedge clk);
        while (!cmd_ready) @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (pending != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name = name;
        err_base = err_count;
    endtask

    task automatic finish_test();
        wait_drained();
        test_fails += (err_count != err_base);
        $display("test %0d, %s: %s", test_num, test_name,
                 (err_count == err_base) ? "ok" : "failed");
    endtask

    initial begin
        int off;
        rst = 1'b1;
        max_size = 3'd2;
        cmd_valid = 1'b0;
        cmd = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // short commands inside one 512-byte block
        start_test("single piece");
        for (int i = 0; i < 8; i++) begin
            off = next_rand(lcg) % 128;
            send_cmd(30'((next_rand(lcg) << 7) | off), 10'(1 + next_rand(lcg) % (128 - off)));
        end
        finish_test();

        // codes 6 and 7 act as 4 KB
        start_test("boundary crossing");
        for (int code = 0; code < 8; code++) begin
            max_size <= code[2:0];
            repeat (3) send_cmd(30'(next_rand(lcg)), 10'(1 + next_rand(lcg) % 1023));
            wait_drained();
        end
        finish_test();

        start_test("1024-dword commands");
        for (int code = 0; code < 6; code++) begin
            max_size <= code[2:0];
            send_cmd(30'(next_rand(lcg) | 1), 10'd0);
            send_cmd(30'(next_rand(lcg) & 32'hffff_fc00), 10'd0);
            wait_drained();
        end
        finish_test();

        start_test("random back-pressure");
        ready_random <= 1'b1;
        repeat (4) begin
            max_size <= 3'(next_rand(lcg) % 6);
            repeat (50) send_cmd(30'(next_rand(lcg)), 10'(next_rand(lcg)));
            wait_drained();
        end
        ready_random <= 1'b0;
        finish_test();

        // ten pieces against eight tags with returns held back
        start_test("tag exhaustion");
        while (tags_free != rdsplit_pkg::num_tags) @(posedge clk);
        release_en <= 1'b0;
        max_size <= 3'd0;
        send_cmd(30'd0, 10'd320);
        while (tags_free != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        off = req_count;
        release_one <= 1'b1;
        @(posedge clk);
        release_one <= 1'b0;
        while (req_count == off) @(posedge clk);
        release_en <= 1'b1;
        finish_test();

        $display("%0d tests, %0d failed, %0d errors", test_num, test_fails, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/rdsplit_pkg.sv
hdl/cmd_queue.sv
hdl/cmd_split.sv
hdl/tag_pool.sv
hdl/rdsplit_top.sv
testbench/rdsplit_checker.sv
testbench/tb_rdsplit.sv
